/* hw/rvIsaPkg.sv */
package rvIsaPkg;

	// one raw instruction word as fetched
	typedef logic [31:0] instWordT;

	// architectural register index
	typedef logic [4:0] regIdxT;

	// low seven bits of every instruction
	typedef logic [6:0] opcodeT;

	// major opcodes used by the hazard logic
	localparam opcodeT OpRType = 7'b0110011;
	localparam opcodeT OpBType = 7'b1100011;
	localparam opcodeT OpSType = 7'b0100011;
	localparam opcodeT OpIType = 7'b0010011;
	localparam opcodeT OpLoad  = 7'b0000011;
	localparam opcodeT OpJal   = 7'b1101111;
	localparam opcodeT OpJalr  = 7'b1100111;
	localparam opcodeT OpLui   = 7'b0110111;
	localparam opcodeT OpAuipc = 7'b0010111;

	// bubble word
	// its opcode field is zero so it matches no class below
	localparam instWordT OpNop = '0;

	// branch conditions in funct3
	localparam logic [2:0] F3Beq  = 3'b000;
	localparam logic [2:0] F3Bne  = 3'b001;
	localparam logic [2:0] F3Blt  = 3'b100;
	localparam logic [2:0] F3Bge  = 3'b101;
	localparam logic [2:0] F3Bltu = 3'b110;
	localparam logic [2:0] F3Bgeu = 3'b111;

	// hardwired zero register
	localparam regIdxT RegZero = 5'd0;

	// field extraction
	// all formats keep these fields at the same bit positions
	function automatic regIdxT rdOf(instWordT w);
		return w[11:7];
	endfunction

	function automatic regIdxT rs1Of(instWordT w);
		return w[19:15];
	endfunction

	function automatic regIdxT rs2Of(instWordT w);
		return w[24:20];
	endfunction

	function automatic logic [2:0] funct3Of(instWordT w);
		return w[14:12];
	endfunction

	function automatic opcodeT opcodeOf(instWordT w);
		return w[6:0];
	endfunction

	// instruction produces a register result
	// stores and branches have no rd
	function automatic logic writesRd(instWordT w);
		opcodeT op;
		op = opcodeOf(w);
		return op inside {OpRType, OpIType, OpLoad, OpJal, OpJalr, OpLui, OpAuipc};
	endfunction

	// instruction consumes rs1
	// lui, auipc and jal take no register source
	function automatic logic readsRs1(instWordT w);
		opcodeT op;
		op = opcodeOf(w);
		return op inside {OpRType, OpBType, OpSType, OpIType, OpLoad, OpJalr};
	endfunction

	// instruction consumes rs2
	function automatic logic readsRs2(instWordT w);
		opcodeT op;
		op = opcodeOf(w);
		return op inside {OpRType, OpBType, OpSType};
	endfunction

endpackage

/* hw/hazardPkg.sv */
package hazardPkg;

	// operand source for an ALU input
	// encoding follows the existing datapath mux
	typedef enum logic [1:0] {
		FwdRegFile = 2'b00,
		FwdWb      = 2'b01,
		FwdMem     = 2'b10
	} fwdSelT;

	// forwarding selects for both EX operands
	typedef struct packed {
		fwdSelT fwdA;
		fwdSelT fwdB;
	} fwdPairT;

	// pipeline flow control toward fetch and decode
	// stall holds pc and IF/ID and drops a bubble into EX
	// flush zeroes IF/ID and ID/EX
	// pcSel picks the next pc source
	typedef struct packed {
		logic stall;
		logic flush;
		logic pcSel;
	} flowCtrlT;

	// next pc source values
	localparam logic PcSelAlu   = 1'b1;
	localparam logic PcSelPlus4 = 1'b0;

	// number of shadowed pipeline registers
	localparam int ShadowDepth = 4;

	// positions in the shadow array
	localparam int StIfId  = 0;
	localparam int StIdEx  = 1;
	localparam int StExMem = 2;
	localparam int StMemWb = 3;

endpackage

/* hw/instShadowPipe.sv */
module instShadowPipe
	import rvIsaPkg::*, hazardPkg::*;
(
	input  logic     clk,
	input  logic     rstN,
	input  instWordT fetchWord,
	input  flowCtrlT flow,
	output instWordT idWord,
	output instWordT exWord,
	output instWordT memWord,
	output instWordT wbWord
);

	// copy of the instruction words held in the real pipeline registers
	// index 0 is IF/ID and the last index is MEM/WB
	instWordT stageQ [ShadowDepth];

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			// every stage starts empty
			for (int i = 0; i < ShadowDepth; i++)
			begin
				stageQ[i] <= OpNop;
			end
		end
		else
		begin
			// back end never stops
			stageQ[StMemWb] <= stageQ[StExMem];
			stageQ[StExMem] <= stageQ[StIdEx];

			if (flow.flush)
			begin
				// wrong path work is squashed
				// fetched word belongs to the old path too
				stageQ[StIfId] <= OpNop;
				stageQ[StIdEx] <= OpNop;
			end
			else if (flow.stall)
			begin
				// decode waits one cycle for the load result
				stageQ[StIfId] <= stageQ[StIfId];
				stageQ[StIdEx] <= OpNop;
			end
			else
			begin
				// normal advance
				stageQ[StIfId] <= fetchWord;
				stageQ[StIdEx] <= stageQ[StIfId];
			end
		end
	end

	// stage taps for the hazard logic
	assign idWord  = stageQ[StIfId];
	assign exWord  = stageQ[StIdEx];
	assign memWord = stageQ[StExMem];
	assign wbWord  = stageQ[StMemWb];

endmodule

/* hw/forwardUnit.sv */
module forwardUnit
	import rvIsaPkg::*, hazardPkg::*;
(
	input  instWordT exWord,
	input  instWordT memWord,
	input  instWordT wbWord,
	output fwdPairT  fwd
);

	// true when a later stage will write the register being read
	// x0 is never a real producer
	function automatic logic producesFor(instWordT w, regIdxT src);
		return writesRd(w) && (rdOf(w) != RegZero) && (rdOf(w) == src);
	endfunction

	// forwarding rule for one source operand
	// nearer producer wins since it holds the newer value
	function automatic fwdSelT pickSource(
		logic     used,
		regIdxT   src,
		instWordT memW,
		instWordT wbW
	);
		fwdSelT sel;
		sel = FwdRegFile;
		if (used && producesFor(memW, src))
		begin
			sel = FwdMem;
		end
		else if (used && producesFor(wbW, src))
		begin
			sel = FwdWb;
		end
		return sel;
	endfunction

	// same rule applied to both operands of the EX instruction
	always_comb
	begin
		// operand A
		fwd.fwdA = pickSource(readsRs1(exWord), rs1Of(exWord), memWord, wbWord);
		// operand B
		fwd.fwdB = pickSource(readsRs2(exWord), rs2Of(exWord), memWord, wbWord);
	end

endmodule

/* hw/flowCtrl.sv */
module flowCtrl
	import rvIsaPkg::*, hazardPkg::*;
(
	input  instWordT idWord,
	input  instWordT exWord,
	input  logic     brEq,
	input  logic     brLt,
	output flowCtrlT flow
);

	// EX instruction class
	opcodeT exOp;
	logic   exJump;
	logic   exBranch;

	// branch outcome from the datapath compare
	logic   brTaken;

	// control transfer leaving EX this cycle
	logic   redirect;

	// load in EX feeding the instruction in ID
	regIdxT loadRd;
	logic   idUsesRs1;
	logic   idUsesRs2;
	logic   loadUse;

	assign exOp     = opcodeOf(exWord);
	assign exJump   = (exOp == OpJal) || (exOp == OpJalr);
	assign exBranch = (exOp == OpBType);

	// condition table by funct3
	// signed and unsigned variants share the flags
	// the datapath already picked the compare kind
	always_comb
	begin
		case (funct3Of(exWord))
			F3Beq:           brTaken = brEq;
			F3Bne:           brTaken = !brEq;
			F3Blt, F3Bltu:   brTaken = brLt;
			F3Bge, F3Bgeu:   brTaken = !brLt;
			// reserved encodings never branch
			default:         brTaken = 1'b0;
		endcase
	end

	// jumps always leave, branches only when taken
	assign redirect = exJump || (exBranch && brTaken);

	// load result arrives too late for EX of the next instruction
	assign loadRd    = rdOf(exWord);
	assign idUsesRs1 = readsRs1(idWord) && (rs1Of(idWord) == loadRd);
	assign idUsesRs2 = readsRs2(idWord) && (rs2Of(idWord) == loadRd);
	assign loadUse   = (exOp == OpLoad) && (loadRd != RegZero) && (idUsesRs1 || idUsesRs2);

	always_comb
	begin
		// redirect squashes IF/ID and ID/EX
		flow.flush = redirect;
		flow.pcSel = redirect ? PcSelAlu : PcSelPlus4;
		// the waiting reader is flushed anyway on a redirect
		flow.stall = loadUse && !redirect;
	end

endmodule

/* hw/hazardTop.sv */
module hazardTop
	import rvIsaPkg::*, hazardPkg::*;
(
	input  logic     clk,
	input  logic     rstN,
	input  instWordT fetchWord,
	input  logic     brEq,
	input  logic     brLt,
	output fwdPairT  fwd,
	output flowCtrlT flow
);

	// shadow stage words
	instWordT idWord;
	instWordT exWord;
	instWordT memWord;
	instWordT wbWord;

	// pipeline copy advanced by our own flow decisions
	instShadowPipe uShadowPipe (
		.clk       (clk),
		.rstN      (rstN),
		.fetchWord (fetchWord),
		.flow      (flow),
		.idWord    (idWord),
		.exWord    (exWord),
		.memWord   (memWord),
		.wbWord    (wbWord)
	);

	// operand bypass selects for EX
	forwardUnit uForwardUnit (
		.exWord  (exWord),
		.memWord (memWord),
		.wbWord  (wbWord),
		.fwd     (fwd)
	);

	// stall, flush and next pc source
	flowCtrl uFlowCtrl (
		.idWord (idWord),
		.exWord (exWord),
		.brEq   (brEq),
		.brLt   (brLt),
		.flow   (flow)
	);

endmodule

/* dv/hazardTop_sva.sv */
module hazardTopSva
	import rvIsaPkg::*, hazardPkg::*;
(
	input logic     clk,
	input logic     rstN,
	input fwdPairT  fwd,
	input flowCtrlT flow,
	input instWordT memWord,
	input instWordT wbWord
);
	timeunit 1ns;
	timeprecision 100ps;

	// shadow stages are all bubbles one edge after reset
	idleAfterReset: assert property (@(posedge clk) !rstN |=> flow == '0)
		else $error("flow is not idle in the cycle after reset");

	// a flushed reader never needs to wait
	stallFlushExclusive: assert property (@(posedge clk) disable iff (!rstN)
		!(flow.stall && flow.flush))
		else $error("stall and flush are high together");

	// only redirects take the ALU target
	pcSelFollowsFlush: assert property (@(posedge clk) disable iff (!rstN)
		flow.pcSel == flow.flush)
		else $error("pcSel differs from flush");

	// x0 results are never bypassed
	noMemFwdFromX0: assert property (@(posedge clk) disable iff (!rstN)
		fwd.fwdA == FwdMem |-> rdOf(memWord) != RegZero)
		else $error("fwdA selects MEM while its rd is x0");

	noWbFwdFromX0: assert property (@(posedge clk) disable iff (!rstN)
		fwd.fwdA == FwdWb |-> rdOf(wbWord) != RegZero)
		else $error("fwdA selects WB while its rd is x0");

endmodule

bind hazardTop hazardTopSva uSva (
	.clk     (clk),
	.rstN    (rstN),
	.fwd     (fwd),
	.flow    (flow),
	.memWord (memWord),
	.wbWord  (wbWord)
);

/* dv/hazardTb.sv */
module hazardTb
	import rvIsaPkg::*, hazardPkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	logic     clk;
	logic     rstN;
	instWordT fetchWord;
	logic     brEq;
	logic     brLt;
	fwdPairT  fwd;
	flowCtrlT flow;

	// expected shadow stages with IF/ID first
	instWordT modelSt [ShadowDepth];
	bit       modelValid;
	int       errors;
	int       checks;
	integer   seed;

	// directed words as {brEq, brLt, word}
	logic [33:0] seqQ [$];

	hazardTop u_dut (
		.clk       (clk),
		.rstN      (rstN),
		.fetchWord (fetchWord),
		.brEq      (brEq),
		.brLt      (brLt),
		.fwd       (fwd),
		.flow      (flow)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	initial
	begin
		rstN = 1'b0;
		repeat (5) @(posedge clk);
		#1 rstN = 1'b1;
	end

	function automatic instWordT encode(opcodeT op, regIdxT rd, regIdxT rs1, regIdxT rs2,
		logic [2:0] f3);
		return {7'b0, rs2, rs1, f3, rd, op};
	endfunction

	// older producer first so the nearer one overrides it
	function automatic fwdSelT expectSel(logic used, regIdxT src, instWordT memW, instWordT wbW);
		fwdSelT sel;
		sel = FwdRegFile;
		if (used && src != RegZero && writesRd(wbW) && rdOf(wbW) == src)
			sel = FwdWb;
		if (used && src != RegZero && writesRd(memW) && rdOf(memW) == src)
			sel = FwdMem;
		return sel;
	endfunction

	// expected controls from the model stages and the current flags
	function automatic void expectCtrl(input logic eq, input logic lt,
		output fwdPairT f, output flowCtrlT fl);
		instWordT   idW;
		instWordT   exW;
		logic [2:0] f3;
		logic       taken;
		logic       loadUse;
		idW = modelSt[StIfId];
		exW = modelSt[StIdEx];
		f.fwdA = expectSel(readsRs1(exW), rs1Of(exW), modelSt[StExMem], modelSt[StMemWb]);
		f.fwdB = expectSel(readsRs2(exW), rs2Of(exW), modelSt[StExMem], modelSt[StMemWb]);
		// funct3 bit 2 picks lt over eq
		// bit 0 inverts the outcome
		// 01x is reserved and never taken
		f3 = funct3Of(exW);
		taken = (opcodeOf(exW) == OpBType) && (f3[2:1] != 2'b01) && (f3[0] ^ (f3[2] ? lt : eq));
		loadUse = (opcodeOf(exW) == OpLoad) && (rdOf(exW) != RegZero)
			&& ((readsRs1(idW) && rs1Of(idW) == rdOf(exW))
			|| (readsRs2(idW) && rs2Of(idW) == rdOf(exW)));
		fl.flush = taken || (opcodeOf(exW) inside {OpJal, OpJalr});
		fl.pcSel = fl.flush;
		// reader is squashed anyway on a redirect
		fl.stall = loadUse && !fl.flush;
	endfunction

	task automatic checkFwd(fwdPairT expVal, fwdPairT actVal);
		checks++;
		if (actVal !== expVal)
		begin
			errors++;
			$display("CHECK FAILED fwd expected %h actual %h at %0t", expVal, actVal, $time);
		end
	endtask

	task automatic checkFlow(flowCtrlT expVal, flowCtrlT actVal);
		checks++;
		if (actVal !== expVal)
		begin
			errors++;
			$display("CHECK FAILED flow expected %h actual %h at %0t", expVal, actVal, $time);
		end
	endtask

	// inputs change 1 ns after the edge
	task automatic issue(instWordT w, logic eq, logic lt);
		@(posedge clk);
		#1;
		fetchWord = w;
		brEq = eq;
		brLt = lt;
	endtask

	// compare 1 ns before the edge and then move the model across it
	always @(posedge clk)
	begin
		fwdPairT  expFwd;
		flowCtrlT expFlow;
		#3;
		if (modelValid)
		begin
			expectCtrl(brEq, brLt, expFwd, expFlow);
			checkFwd(expFwd, fwd);
			checkFlow(expFlow, flow);
		end
		if (!rstN)
		begin
			foreach (modelSt[i])
				modelSt[i] = OpNop;
			modelValid = 1'b1;
		end
		else if (modelValid)
		begin
			modelSt[StMemWb] = modelSt[StExMem];
			modelSt[StExMem] = modelSt[StIdEx];
			if (expFlow.flush)
			begin
				modelSt[StIdEx] = OpNop;
				modelSt[StIfId] = OpNop;
			end
			else if (expFlow.stall)
				modelSt[StIdEx] = OpNop;
			else
			begin
				modelSt[StIdEx] = modelSt[StIfId];
				modelSt[StIfId] = fetchWord;
			end
		end
	end

	initial
	begin
		int          waitCount;
		int          pick;
		opcodeT      ops [9];
		logic [2:0]  f3List [6];
		logic [31:0] flags;
		instWordT    w;
		seed = 32'hc713_d1a8;
		errors = 0;
		checks = 0;
		fetchWord = OpNop;
		brEq = 1'b0;
		brLt = 1'b0;
		ops = '{OpRType, OpBType, OpSType, OpIType, OpLoad, OpJal, OpJalr, OpLui, OpAuipc};
		f3List = '{F3Beq, F3Bne, F3Blt, F3Bge, F3Bltu, F3Bgeu};

		waitCount = 0;
		while (rstN !== 1'b1 && waitCount < 20)
		begin
			@(posedge clk);
			waitCount++;
		end
		if (rstN !== 1'b1)
		begin
			$display("timeout: reset was never released");
			$display("Done: errors found");
			$finish;
		end

		// idle after reset
		repeat (2) seqQ.push_back({2'b00, OpNop});
		// x1 read by the next two and then two writers of x4
		seqQ.push_back({2'b00, encode(OpIType, 5'd1, 5'd0, 5'd0, 3'd0)});
		seqQ.push_back({2'b00, encode(OpRType, 5'd2, 5'd1, 5'd1, 3'd0)});
		seqQ.push_back({2'b00, encode(OpRType, 5'd3, 5'd1, 5'd2, 3'd0)});
		seqQ.push_back({2'b00, encode(OpLui, 5'd4, 5'd0, 5'd0, 3'd0)});
		seqQ.push_back({2'b00, encode(OpAuipc, 5'd4, 5'd0, 5'd0, 3'd0)});
		seqQ.push_back({2'b00, encode(OpSType, 5'd0, 5'd4, 5'd4, 3'd2)});
		// x0 writes never forward
		seqQ.push_back({2'b00, encode(OpIType, 5'd0, 5'd1, 5'd0, 3'd0)});
		seqQ.push_back({2'b00, encode(OpRType, 5'd5, 5'd0, 5'd0, 3'd0)});
		// load then a direct reader that is held one cycle
		seqQ.push_back({2'b00, encode(OpLoad, 5'd2, 5'd1, 5'd0, 3'd2)});
		seqQ.push_back({2'b00, encode(OpRType, 5'd3, 5'd2, 5'd0, 3'd0)});
		repeat (3) seqQ.push_back({2'b00, OpNop});
		// jumps with two readers behind them that get squashed
		seqQ.push_back({2'b00, encode(OpJal, 5'd1, 5'd0, 5'd0, 3'd0)});
		seqQ.push_back({2'b00, encode(OpRType, 5'd2, 5'd1, 5'd1, 3'd0)});
		seqQ.push_back({2'b00, encode(OpIType, 5'd3, 5'd1, 5'd0, 3'd0)});
		seqQ.push_back({2'b00, encode(OpJalr, 5'd1, 5'd2, 5'd0, 3'd0)});
		repeat (3) seqQ.push_back({2'b00, OpNop});
		// every branch condition against every flag pair
		foreach (f3List[i])
		begin
			for (int c = 0; c < 4; c++)
			begin
				seqQ.push_back({c[1:0], encode(OpBType, 5'd0, 5'd1, 5'd2, f3List[i])});
				repeat (3) seqQ.push_back({c[1:0], OpNop});
			end
		end
		foreach (seqQ[i])
			issue(seqQ[i][31:0], seqQ[i][33], seqQ[i][32]);

		// random words over registers x0..x3 so hazards are frequent
		for (int k = 0; k < 2000; k++)
		begin
			pick = $unsigned($random(seed)) % 10;
			w = $random(seed);
			flags = $random(seed);
			if (pick == 9)
				w = OpNop;
			else
				w = encode(ops[pick], {3'b0, w[8:7]}, {3'b0, w[16:15]}, {3'b0, w[21:20]},
					w[14:12]);
			issue(w, flags[1], flags[0]);
		end
		repeat (4) issue(OpNop, 1'b0, 1'b0);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

/* files.f */
hw/rvIsaPkg.sv
hw/hazardPkg.sv
hw/instShadowPipe.sv
hw/forwardUnit.sv
hw/flowCtrl.sv
hw/hazardTop.sv
dv/hazardTop_sva.sv
dv/hazardTb.sv

/* Bender.yml */
package:
  name: hazard_ctrl

sources:
  # packages first, then the RTL
  - hw/rvIsaPkg.sv
  - hw/hazardPkg.sv
  - hw/instShadowPipe.sv
  - hw/forwardUnit.sv
  - hw/flowCtrl.sv
  - hw/hazardTop.sv
  # assertions and testbench
  - target: test
    files:
      - dv/hazardTop_sva.sv
      - dv/hazardTb.sv
